// ==== logic/frontend_pkg.sv ====
// Line geometry is fixed at 64 bytes and six slots, so changing LINE_BYTES alone is not enough
package frontend_pkg;

	// ==================================================
	// Line geometry
	// ==================================================

	// Bytes in one cache line as delivered by the instruction cache
	localparam int LINE_BYTES = 64;
	localparam int LINE_BITS = LINE_BYTES * 8;
	// Bits needed to address one byte inside the line
	localparam int OFF_BITS = $clog2(LINE_BYTES);

	// Instructions decoded from a single line per fetch
	localparam int SLOTS = 6;
	// The longest encoding sets the width of a slot's instruction field
	localparam int MAX_LEN = 6;
	localparam int INS_BITS = MAX_LEN * 8;

	// Instruction queue geometry
	localparam int QUEUE_DEPTH = 16;
	localparam int QPTR_BITS = $clog2(QUEUE_DEPTH);

	// ==================================================
	// Basic types
	// ==================================================

	typedef logic [31:0] pc_address_t;
	// Lengths run from 1 to 6, never 0
	typedef logic [2:0] ins_len_t;
	// One spare bit above the byte offset keeps a start beyond the line visible
	typedef logic [OFF_BITS:0] line_off_t;
	typedef logic [QPTR_BITS-1:0] q_ptr_t;
	typedef logic [QPTR_BITS:0] q_cnt_t;

	// Fetch address held by the latch coming out of reset
	localparam pc_address_t RST_PC = 32'hFFFC0000;

	// Length for each value of the two top opcode bits
	localparam ins_len_t LEN_00 = 3'd1;
	localparam ins_len_t LEN_01 = 3'd2;
	localparam ins_len_t LEN_10 = 3'd4;
	localparam ins_len_t LEN_11 = 3'd6;

	// ==================================================
	// Bundles
	// ==================================================

	// A registered cache line together with its address and hit flag
	typedef struct packed {
		logic hit;
		pc_address_t pc;
		logic [LINE_BITS-1:0] line;
	} fetch_line_t;

	// One extracted instruction, first byte in the low bits, zero filled above len
	typedef struct packed {
		logic [INS_BITS-1:0] ins;
		pc_address_t pc;
		ins_len_t len;
	} ins_slot_t;

	// Only bits 7:6 of the first byte matter, the rest is opcode space
	function automatic ins_len_t len_of_byte(input logic [7:0] op);
		ins_len_t len;
		unique case (op[7:6])
			2'b00: len = LEN_00;
			2'b01: len = LEN_01;
			2'b10: len = LEN_10;
			2'b11: len = LEN_11;
		endcase
		return len;
	endfunction

endpackage

// ==== logic/fetch_latch.sv ====
// The cache must keep presenting a line while hold_i is high, since a held edge samples nothing
module fetch_latch (
	input logic clk_i,
	input logic rst_i,
	input logic hit_i,
	input frontend_pkg::pc_address_t pc_i,
	input logic [frontend_pkg::LINE_BITS-1:0] line_i,
	input logic hold_i,
	output frontend_pkg::fetch_line_t fl_o
);

	// ==================================================
	// Line register
	// ==================================================

	// The whole bundle loads together so address, line and hit never drift apart
	// A hit that arrives while holding is simply not sampled
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			// A miss with an all ones line decodes as invalid slots downstream
			fl_o.hit <= 1'b0;
			fl_o.pc <= frontend_pkg::RST_PC;
			fl_o.line <= '1;
		end
		else if (!hold_i) begin
			fl_o.hit <= hit_i;
			fl_o.pc <= pc_i;
			fl_o.line <= line_i;
		end
	end

	// Between hold edges the length decoder keeps chewing on the same line,
	// which is what lets the aligner pick it up later without a refetch

	// Note that a line without a hit still loads and is decoded
	// The aligner masks every slot of such a line to invalid

	// ==================================================
	// Checks
	// ==================================================

	// Held contents must survive the edge untouched, otherwise a line
	// sitting here during back-pressure would be lost or corrupted
	a_hold_stable: assert property (
		@(posedge clk_i) disable iff (rst_i)
		hold_i |=> $stable(fl_o)
	);

endmodule

// ==== logic/ins_lengths_l0.sv ====
// Purely combinational, so its delay adds to the aligner's input path in the same cycle
module ins_lengths_l0 (
	input frontend_pkg::fetch_line_t fl_i,
	output frontend_pkg::line_off_t [frontend_pkg::SLOTS-1:0] start_o,
	output frontend_pkg::ins_len_t [frontend_pkg::SLOTS-1:0] len_o
);

	// ==================================================
	// Per byte length decode
	// ==================================================

	// Every byte of the line is treated as a possible first byte
	// The chain below then picks the ones that really start an instruction
	frontend_pkg::ins_len_t [frontend_pkg::LINE_BYTES-1:0] byte_len;

	// All 64 decoders work in parallel, independent of the fetch offset
	always_comb begin
		for (int b = 0; b < frontend_pkg::LINE_BYTES; b++) begin
			byte_len[b] = frontend_pkg::len_of_byte(fl_i.line[b*8 +: 8]);
		end
	end

	// ==================================================
	// Slot chain
	// ==================================================

	// Slot 0 starts at the fetch offset inside the line
	// Each later slot starts where the previous one ends
	// The spare top bit of an offset flags a start beyond byte 63
	always_comb begin : p_chain
		frontend_pkg::line_off_t pos;
		frontend_pkg::ins_len_t ln;
		pos = {1'b0, fl_i.pc[frontend_pkg::OFF_BITS-1:0]};
		for (int s = 0; s < frontend_pkg::SLOTS; s++) begin
			// Past the line there is no byte to look at
			// A length of 1 keeps the chain moving without reading garbage
			if (pos[frontend_pkg::OFF_BITS]) begin
				ln = frontend_pkg::ins_len_t'(1);
			end
			else begin
				ln = byte_len[pos[frontend_pkg::OFF_BITS-1:0]];
			end
			start_o[s] = pos;
			len_o[s] = ln;
			// Worst case is 63 plus five six byte steps, well inside 7 bits
			pos = pos + frontend_pkg::line_off_t'(ln);
		end
	end

	// The adders form a ripple of six small sums, each feeding a
	// 64 to 1 mux of 3 bit lengths, which dominates the path

	// Whether a slot actually fits in the line is left to the aligner,
	// which also knows whether the line was a hit at all

endmodule

// ==== logic/ins_align.sv ====
// Instructions crossing the line end are dropped here and refetched through next_pc_o
module ins_align (
	input logic clk_i,
	input logic rst_i,
	input frontend_pkg::fetch_line_t fl_i,
	input frontend_pkg::line_off_t [frontend_pkg::SLOTS-1:0] start_i,
	input frontend_pkg::ins_len_t [frontend_pkg::SLOTS-1:0] len_i,
	input logic hold_i,
	output frontend_pkg::ins_slot_t [frontend_pkg::SLOTS-1:0] slot_o,
	output logic [frontend_pkg::SLOTS-1:0] valid_o,
	output frontend_pkg::pc_address_t next_pc_o,
	output logic next_pc_valid_o
);

	// End offset of each slot, start plus length
	frontend_pkg::line_off_t [frontend_pkg::SLOTS-1:0] end_off;
	// Slot ends inside the line
	logic [frontend_pkg::SLOTS-1:0] fit;
	// Slot fits, line hit and every earlier slot also valid
	logic [frontend_pkg::SLOTS-1:0] vld;
	frontend_pkg::ins_slot_t [frontend_pkg::SLOTS-1:0] slot_d;
	frontend_pkg::line_off_t next_off;
	frontend_pkg::pc_address_t next_pc_d;

	// ==================================================
	// Slot validity
	// ==================================================

	always_comb begin
		for (int s = 0; s < frontend_pkg::SLOTS; s++) begin
			end_off[s] = start_i[s] + frontend_pkg::line_off_t'(len_i[s]);
			// Ending exactly on byte 64 still counts as inside
			fit[s] = end_off[s] <= frontend_pkg::line_off_t'(frontend_pkg::LINE_BYTES);
		end
		// Once one slot fails, all later ones fail with it
		vld[0] = fl_i.hit && fit[0];
		for (int s = 1; s < frontend_pkg::SLOTS; s++) begin
			vld[s] = vld[s-1] && fit[s];
		end
	end

	// ==================================================
	// Extraction
	// ==================================================

	// Each slot gets its own byte shifter so that all six run in parallel
	always_comb begin : p_extract
		logic [frontend_pkg::LINE_BITS-1:0] line_sh;
		for (int s = 0; s < frontend_pkg::SLOTS; s++) begin
			line_sh = fl_i.line >> {start_i[s][frontend_pkg::OFF_BITS-1:0], 3'b000};
			slot_d[s].ins = '0;
			// Bytes beyond the length stay zero
			for (int b = 0; b < frontend_pkg::MAX_LEN; b++) begin
				if (b < len_i[s]) begin
					slot_d[s].ins[b*8 +: 8] = line_sh[b*8 +: 8];
				end
			end
			// The slot address keeps the line base and swaps in the offset
			slot_d[s].pc = {fl_i.pc[31:frontend_pkg::OFF_BITS],
				start_i[s][frontend_pkg::OFF_BITS-1:0]};
			slot_d[s].len = len_i[s];
			// Invalid slots are blanked so nothing stale leaks into the queue
			if (!vld[s]) begin
				slot_d[s] = '0;
			end
		end
	end

	// ==================================================
	// Next fetch address
	// ==================================================

	// Scanning down leaves the lowest invalid start in next_off
	// If all six are valid, the end of the last one is used
	always_comb begin
		next_off = end_off[frontend_pkg::SLOTS-1];
		for (int s = frontend_pkg::SLOTS - 1; s >= 0; s--) begin
			if (!vld[s]) begin
				next_off = start_i[s];
			end
		end
		// An offset of 64 carries into the line address through the add
		next_pc_d = {fl_i.pc[31:frontend_pkg::OFF_BITS], {frontend_pkg::OFF_BITS{1'b0}}}
			+ frontend_pkg::pc_address_t'(next_off);
	end

	// ==================================================
	// Group register
	// ==================================================

	// The valid mask is held under back-pressure, but the next_pc strobe
	// only fires on the edge that actually takes in a new line
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			valid_o <= '0;
			next_pc_valid_o <= 1'b0;
		end
		else if (!hold_i) begin
			valid_o <= vld;
			next_pc_valid_o <= fl_i.hit;
		end
		else begin
			next_pc_valid_o <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!hold_i) begin
			slot_o <= slot_d;
			next_pc_o <= next_pc_d;
		end
	end

	// The queue writes in order from slot 0, so a gap would misplace instructions
	a_valid_contiguous: assert property (
		@(posedge clk_i) disable iff (rst_i)
		(valid_o & (valid_o + 1'b1)) == '0
	);

endmodule

// ==== logic/ins_queue.sv ====
// Accepts a group only when SLOTS entries are free, so upstream must stall on room_o low
module ins_queue (
	input logic clk_i,
	input logic rst_i,
	input frontend_pkg::ins_slot_t [frontend_pkg::SLOTS-1:0] slot_i,
	input logic [frontend_pkg::SLOTS-1:0] valid_i,
	input logic stall_i,
	output logic room_o,
	output frontend_pkg::ins_slot_t ins_o,
	output logic ins_valid_o
);

	// Storage is a plain array, the pointers wrap naturally at the depth
	frontend_pkg::ins_slot_t mem [frontend_pkg::QUEUE_DEPTH];
	frontend_pkg::q_ptr_t head;
	frontend_pkg::q_ptr_t tail;
	frontend_pkg::q_cnt_t count;
	// Number of valid slots offered this cycle
	frontend_pkg::q_cnt_t n_in;
	// Number of entries actually written this edge
	frontend_pkg::q_cnt_t n_wr;
	logic pop;

	// ==================================================
	// Status
	// ==================================================

	// Room for a full group regardless of how many slots it carries
	assign room_o = count <= frontend_pkg::q_cnt_t'(frontend_pkg::QUEUE_DEPTH
		- frontend_pkg::SLOTS);
	assign ins_valid_o = count != '0;
	// Head leaves when the consumer is not stalling
	assign pop = ins_valid_o && !stall_i;
	// The head entry is shown directly from the array
	assign ins_o = mem[head];

	// The mask is contiguous from slot 0, so a plain bit count gives the length
	always_comb begin
		n_in = '0;
		for (int s = 0; s < frontend_pkg::SLOTS; s++) begin
			n_in = n_in + frontend_pkg::q_cnt_t'(valid_i[s]);
		end
		n_wr = room_o ? n_in : '0;
	end

	// ==================================================
	// Write port
	// ==================================================

	// Slot s lands at tail plus s, keeping program order
	always_ff @(posedge clk_i) begin
		if (room_o) begin
			for (int s = 0; s < frontend_pkg::SLOTS; s++) begin
				if (valid_i[s]) begin
					mem[frontend_pkg::q_ptr_t'(tail + s)] <= slot_i[s];
				end
			end
		end
	end

	// ==================================================
	// Pointers and count
	// ==================================================

	// A pop and a write can share an edge, the count takes both into account
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end
		else begin
			tail <= tail + frontend_pkg::q_ptr_t'(n_wr);
			if (pop) begin
				head <= head + 1'b1;
			end
			count <= count + n_wr - frontend_pkg::q_cnt_t'(pop);
		end
	end

	// ==================================================
	// Checks
	// ==================================================

	a_count_bound: assert property (
		@(posedge clk_i) disable iff (rst_i)
		count <= frontend_pkg::q_cnt_t'(frontend_pkg::QUEUE_DEPTH)
	);

	// With room low the held group must not enter, so the count cannot grow
	a_no_write_full: assert property (
		@(posedge clk_i) disable iff (rst_i)
		!room_o |=> count <= $past(count)
	);

endmodule

// ==== logic/fetch_frontend.sv ====
// The cache must hold hit_i, pc_i and line_i steady while stall_o is high
module fetch_frontend (
	input logic clk_i,
	input logic rst_i,
	input logic hit_i,
	input frontend_pkg::pc_address_t pc_i,
	input logic [frontend_pkg::LINE_BITS-1:0] line_i,
	input logic stall_i,
	output logic stall_o,
	output frontend_pkg::ins_slot_t ins_o,
	output logic ins_valid_o,
	output frontend_pkg::pc_address_t next_pc_o,
	output logic next_pc_valid_o
);

	frontend_pkg::fetch_line_t fl;
	frontend_pkg::line_off_t [frontend_pkg::SLOTS-1:0] start;
	frontend_pkg::ins_len_t [frontend_pkg::SLOTS-1:0] len;
	frontend_pkg::ins_slot_t [frontend_pkg::SLOTS-1:0] slot;
	logic [frontend_pkg::SLOTS-1:0] slot_valid;
	logic room;

	// One stall level freezes both register stages together
	assign stall_o = !room;

	// ==================================================
	// Pipeline
	// ==================================================

	fetch_latch u_latch (
		.clk_i(clk_i), .rst_i(rst_i), .hit_i(hit_i), .pc_i(pc_i),
		.line_i(line_i), .hold_i(stall_o), .fl_o(fl)
	);

	// Same cycle as the latch output, no register here
	ins_lengths_l0 u_lengths (.fl_i(fl), .start_o(start), .len_o(len));

	ins_align u_align (
		.clk_i(clk_i), .rst_i(rst_i), .fl_i(fl), .start_i(start), .len_i(len),
		.hold_i(stall_o), .slot_o(slot), .valid_o(slot_valid),
		.next_pc_o(next_pc_o), .next_pc_valid_o(next_pc_valid_o)
	);

	// The aligner's group enters on every edge with room
	// An edge without a new line leaves its mask at zero
	ins_queue u_queue (
		.clk_i(clk_i), .rst_i(rst_i), .slot_i(slot), .valid_i(slot_valid),
		.stall_i(stall_i), .room_o(room), .ins_o(ins_o), .ins_valid_o(ins_valid_o)
	);

endmodule

// ==== test/frontend_checker.sv ====
// Watches DUT ports only; assumes at most 64 table entries and that the top calls report at the end
module frontend_checker (
	input logic clk_i,
	input logic rst_i,
	input logic hit_i,
	input frontend_pkg::pc_address_t pc_i,
	input logic [frontend_pkg::LINE_BITS-1:0] line_i,
	input logic stall_i,
	input logic dut_stall_i,
	input frontend_pkg::ins_slot_t ins_i,
	input logic ins_valid_i,
	input frontend_pkg::pc_address_t next_pc_i,
	input logic next_pc_valid_i,
	input int entry_i,
	input int want_i
);
	timeunit 1ns;
	timeprecision 100ps;

	// Expected instructions in program order, each tagged with its table entry
	frontend_pkg::ins_slot_t exp_ins [$];
	int exp_tag [$];
	frontend_pkg::pc_address_t exp_pc [$];
	int want_cnt [64];
	int got_cnt [64];
	int value_errs = 0;
	logic seen_hit = 1'b0;
	logic saw_stall = 1'b0;

	initial begin
		for (int t = 0; t < 64; t++) begin
			want_cnt[t] = -1;
			got_cnt[t] = 0;
		end
	end

	// Length from the two top bits of the first byte
	function automatic int opcode_length(input logic [7:0] op);
		case (op[7:6])
			2'b00: return 1;
			2'b01: return 2;
			2'b10: return 4;
			default: return 6;
		endcase
	endfunction

	// ==================================================
	// Reference model
	// ==================================================

	// Chains slots from the fetch offset and stops at the first one that leaves the line
	task automatic expect_line(input logic [31:0] pc, input logic [511:0] line, input int tag);
		frontend_pkg::ins_slot_t s;
		logic [31:0] base;
		int pos;
		int len;
		logic fits;
		base = {pc[31:6], 6'd0};
		pos = int'(pc[5:0]);
		fits = 1'b1;
		for (int k = 0; k < frontend_pkg::SLOTS; k++) begin
			if (fits) begin
				len = (pos < frontend_pkg::LINE_BYTES) ? opcode_length(line[pos*8 +: 8]) : 1;
				if (pos + len > frontend_pkg::LINE_BYTES) begin
					fits = 1'b0;
				end
				else begin
					s.ins = '0;
					for (int b = 0; b < len; b++) begin
						s.ins[b*8 +: 8] = line[(pos+b)*8 +: 8];
					end
					s.pc = base + pos[31:0];
					s.len = len[2:0];
					exp_ins.push_back(s);
					exp_tag.push_back(tag);
					pos = pos + len;
				end
			end
		end
		// Either the first slot left out or the end of the sixth
		exp_pc.push_back(base + pos[31:0]);
	endtask

	// ==================================================
	// Port monitor
	// ==================================================

	always @(posedge clk_i) begin
		if (!rst_i) begin
			if (!seen_hit && (ins_valid_i || next_pc_valid_i || dut_stall_i)) begin
				$display("Error at %0t: outputs active before the first hit", $time);
				value_errs++;
			end
			if (dut_stall_i) begin
				saw_stall = 1'b1;
			end
			if (hit_i && !dut_stall_i) begin
				seen_hit = 1'b1;
				want_cnt[entry_i] = want_i;
				expect_line(pc_i, line_i, entry_i);
			end
			// The head leaves on this edge
			if (ins_valid_i && !stall_i) begin
				if (exp_ins.size() == 0) begin
					$display("Error at %0t: unexpected instruction at pc %h", $time, ins_i.pc);
					value_errs++;
				end
				else begin
					got_cnt[exp_tag[0]]++;
					if (ins_i !== exp_ins[0]) begin
						$display("Error at %0t: got pc %h len %0d ins %h, expected pc %h len %0d ins %h",
							$time, ins_i.pc, ins_i.len, ins_i.ins,
							exp_ins[0].pc, exp_ins[0].len, exp_ins[0].ins);
						value_errs++;
					end
					exp_ins.delete(0);
					exp_tag.delete(0);
				end
			end
			if (next_pc_valid_i) begin
				if (exp_pc.size() == 0) begin
					$display("Error at %0t: next_pc pulse %h with no line pending", $time, next_pc_i);
					value_errs++;
				end
				else begin
					if (next_pc_i !== exp_pc[0]) begin
						$display("Error at %0t: next_pc %h, expected %h", $time, next_pc_i, exp_pc[0]);
						value_errs++;
					end
					exp_pc.delete(0);
				end
			end
		end
	end

	// Prints the closing counts and hands back the total
	task automatic report(output int total);
		int missing;
		int other;
		missing = exp_ins.size() + exp_pc.size();
		other = 0;
		for (int t = 0; t < 64; t++) begin
			if (want_cnt[t] >= 0 && got_cnt[t] != want_cnt[t]) begin
				$display("Entry %0d issued %0d instructions instead of %0d", t, got_cnt[t], want_cnt[t]);
				other++;
			end
		end
		if (!saw_stall) begin
			$display("stall_o never went high while the consumer was stalled");
			other++;
		end
		$display("Value errors: %0d, missing outputs: %0d, other failures: %0d",
			value_errs, missing, other);
		total = value_errs + missing + other;
	endtask

endmodule

// ==== test/tb_frontend.sv ====
// Lines are sent one at a time with a gap cycle; stall_i windows can span several later lines
module tb_frontend;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_ENTRIES = 40;
	localparam int TIMEOUT_CYCLES = N_ENTRIES * 20 + 200;
	// Line fill kinds
	localparam logic [1:0] K_SHORT = 2'd0;
	localparam logic [1:0] K_MIXED = 2'd1;
	localparam logic [1:0] K_LONG = 2'd2;
	localparam logic [1:0] K_RAND = 2'd3;

	// One table row, want is -1 where the checker model alone decides the count
	typedef struct packed {
		logic [31:0] base;
		logic [5:0] off;
		logic [1:0] kind;
		logic [7:0] stall;
		logic signed [7:0] want;
	} stim_t;

	logic clk = 1'b0;
	logic rst, hit, stall_in, stall_out, ins_valid, next_pc_valid;
	frontend_pkg::pc_address_t pc, next_pc;
	logic [frontend_pkg::LINE_BITS-1:0] line;
	frontend_pkg::ins_slot_t ins;
	int entry, want;
	int cycles = 0;
	int stall_until = 0;
	stim_t tbl [$];

	always #10 clk = ~clk;

	fetch_frontend dut (
		.clk_i(clk), .rst_i(rst), .hit_i(hit), .pc_i(pc), .line_i(line), .stall_i(stall_in),
		.stall_o(stall_out), .ins_o(ins), .ins_valid_o(ins_valid), .next_pc_o(next_pc),
		.next_pc_valid_o(next_pc_valid)
	);

	frontend_checker chk (
		.clk_i(clk), .rst_i(rst), .hit_i(hit), .pc_i(pc), .line_i(line), .stall_i(stall_in),
		.dut_stall_i(stall_out), .ins_i(ins), .ins_valid_i(ins_valid), .next_pc_i(next_pc),
		.next_pc_valid_i(next_pc_valid), .entry_i(entry), .want_i(want)
	);

	// Run limit scales with the number of table rows
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	task automatic add_entry(input logic [31:0] base, input int off, input logic [1:0] kind,
		input int stall, input int want_n);
		stim_t s;
		s.base = base;
		s.off = off[5:0];
		s.kind = kind;
		s.stall = stall[7:0];
		s.want = want_n[7:0];
		tbl.push_back(s);
	endtask

	// Low six bits hash the line base and byte index, top bits follow the kind
	function automatic logic [511:0] build_line(input logic [31:0] base, input logic [1:0] kind);
		logic [511:0] l;
		logic [31:0] r;
		logic [1:0] top;
		int v;
		for (int i = 0; i < 64; i++) begin
			v = (base[7:0] ^ base[15:8] ^ base[23:16] ^ base[31:24]) + i * 37;
			top = (kind == K_MIXED) ? i[1:0] : ((kind == K_LONG) ? 2'b11 : 2'b00);
			r = $urandom;
			l[i*8 +: 8] = (kind == K_RAND) ? r[7:0] : {top, v[5:0]};
		end
		return l;
	endfunction

	// One clock step, stall_i follows the current stall window
	task automatic tick();
		@(posedge clk);
		stall_in <= (cycles < stall_until);
	endtask

	// Presents one line and keeps it until an edge with stall_o low takes it
	task automatic send_entry(input int e);
		logic accepted;
		accepted = 1'b0;
		if (cycles + tbl[e].stall > stall_until) begin
			stall_until = cycles + tbl[e].stall;
		end
		tick();
		hit <= 1'b1;
		pc <= tbl[e].base | {26'd0, tbl[e].off};
		line <= build_line(tbl[e].base, tbl[e].kind);
		entry <= e;
		want <= tbl[e].want;
		while (!accepted) begin
			tick();
			if (!stall_out) begin
				accepted = 1'b1;
				hit <= 1'b0;
			end
		end
	endtask

	// ==================================================
	// Main sequence
	// ==================================================

	initial begin : p_main
		int fails;
		int quiet;
		logic [31:0] r;
		void'($urandom(86));
		rst = 1'b1;
		hit = 1'b0;
		pc = '0;
		line = '0;
		stall_in = 1'b0;
		entry = 0;
		want = -1;
		// Directed rows: base, offset, kind, stall cycles, issued count
		add_entry(32'h0000_1000, 0, K_SHORT, 0, 6);
		add_entry(32'h0000_1040, 10, K_SHORT, 0, 6);
		add_entry(32'h0000_1080, 59, K_SHORT, 0, 5);
		add_entry(32'h0000_10C0, 63, K_SHORT, 0, 1);
		add_entry(32'h0000_2000, 0, K_MIXED, 0, 6);
		add_entry(32'h0000_2040, 2, K_MIXED, 0, 6);
		add_entry(32'h0000_2080, 45, K_MIXED, 0, 5);
		add_entry(32'h0000_20C0, 50, K_MIXED, 0, 3);
		// Long consumer stall while full lines keep coming, so the queue fills
		add_entry(32'h0000_2100, 27, K_MIXED, 30, 6);
		add_entry(32'h0000_2140, 20, K_MIXED, 0, 6);
		add_entry(32'h0000_2180, 44, K_MIXED, 0, 6);
		add_entry(32'h0000_21C0, 0, K_LONG, 0, 6);
		add_entry(32'h0000_3000, 57, K_MIXED, 0, 1);
		add_entry(32'h0000_3040, 60, K_MIXED, 0, 2);
		add_entry(32'h0000_3080, 59, K_MIXED, 0, 0);
		add_entry(32'h0000_4000, 30, K_LONG, 0, 5);
		add_entry(32'h0000_4040, 40, K_LONG, 25, 4);
		add_entry(32'h0000_4080, 0, K_SHORT, 0, 6);
		add_entry(32'h0000_40C0, 0, K_LONG, 0, 6);
		add_entry(32'h0000_4100, 58, K_LONG, 0, 1);
		add_entry(32'h0000_4140, 59, K_LONG, 0, 0);
		add_entry(32'h0000_4180, 63, K_LONG, 0, 0);
		add_entry(32'hFFFF_FFC0, 50, K_LONG, 0, 2);
		// Six short ones end exactly on byte 64, so next_pc carries into the next line
		add_entry(32'h0000_5000, 58, K_SHORT, 0, 6);
		while (tbl.size() < N_ENTRIES) begin
			r = $urandom;
			add_entry({r[31:6], 6'd0}, int'(r[5:0]), K_RAND, (r[9:8] == 2'b00) ? r[13:10] + 4 : 0, -1);
		end
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		repeat (5) tick();
		for (int e = 0; e < tbl.size(); e++) begin
			send_entry(e);
		end
		// Drain until the outputs have been quiet for a while
		quiet = 0;
		while (quiet < 12) begin
			tick();
			quiet = (ins_valid || next_pc_valid || stall_out) ? 0 : quiet + 1;
		end
		chk.report(fails);
		if (fails == 0) begin
			$display("NO ERRORS");
		end
		else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== list.f ====
logic/frontend_pkg.sv
logic/fetch_latch.sv
logic/ins_lengths_l0.sv
logic/ins_align.sv
logic/ins_queue.sv
logic/fetch_frontend.sv
test/frontend_checker.sv
test/tb_frontend.sv
